// File: src.f
verilog/rename_pkg.sv
verilog/rename_map.sv
verilog/arch_regfile.sv
verilog/operand_merge.sv
verilog/rename_stage.sv
test/rename_stage_asserts.sv
test/rename_stage_tb.sv

// File: test/rename_stage_asserts.sv
`timescale 1ns/100ps

module rename_stage_asserts (
  input logic                                                 clk,
  input logic                                                 rst_n,
  input logic                                                 flush_i,
  input logic                                                 in_ready_i,
  input logic                                                 out_valid_i,
  input logic                                                 out_ready_i,
  input rename_pkg::dispatch_slot_t [rename_pkg::NUM_SLOTS-1:0] dispatch_i,
  input rename_pkg::rob_cnt_t                                 inflight_i
);

  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid_i && !out_ready_i && !flush_i |=> out_valid_i && $stable(dispatch_i))
    else $error("dispatch changed or dropped while stalled");

  flush_blocks: assert property (@(posedge clk) disable iff (!rst_n) flush_i |-> !in_ready_i)
    else $error("bundle input ready during flush");

  flush_drops: assert property (@(posedge clk) disable iff (!rst_n) flush_i |=> !out_valid_i)
    else $error("dispatch still valid after flush");

  cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
      inflight_i <= rename_pkg::ROB_DEPTH)
    else $error("in-flight count above ROB depth");

endmodule

bind rename_stage rename_stage_asserts i_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .flush_i    (flush_i),
  .in_ready_i (in_ready_o),
  .out_valid_i(out_valid_o),
  .out_ready_i(out_ready_i),
  .dispatch_i (dispatch_o),
  .inflight_i (i_map.inflight_q)
);

// File: test/rename_stage_tb.sv
`timescale 1ns/100ps

module rename_stage_tb;

  typedef rename_pkg::rename_slot_t   [rename_pkg::NUM_SLOTS-1:0] bundle_t;
  typedef rename_pkg::commit_port_t   [rename_pkg::NUM_SLOTS-1:0] commit_t;
  typedef rename_pkg::dispatch_slot_t [rename_pkg::NUM_SLOTS-1:0] disp_t;

  logic    clk, rst_n, in_valid_i, in_ready_o, flush_i, out_valid_o, out_ready_i;
  bundle_t bundle_i;
  commit_t commit_i;
  disp_t   dispatch_o;

  // reference model state
  logic [rename_pkg::ARCH_REGS-1:0] m_busy;
  rename_pkg::rob_tag_t             m_tag [rename_pkg::ARCH_REGS];
  rename_pkg::word_t                m_regs [rename_pkg::ARCH_REGS];
  rename_pkg::rob_tag_t             m_ptr;
  int                               m_cnt;
  logic                             m_valid, last_acc;
  logic [8:0]                       rob_q [$];
  disp_t                            exp_q [$];
  int                               checks, errors, err_mark, accepts, n;

  rename_stage i_dut (.clk(clk), .rst_n(rst_n), .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
    .bundle_i(bundle_i), .commit_i(commit_i), .flush_i(flush_i), .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i), .dispatch_o(dispatch_o));

  always #50 clk = ~clk;

  function automatic logic writes(input rename_pkg::commit_port_t c);
    return c.valid && c.we && c.dst != '0;
  endfunction

  // mappings retired this cycle, only if still pointing at the committing tag
  function automatic logic [rename_pkg::ARCH_REGS-1:0] clear_mask(input commit_t c);
    logic [rename_pkg::ARCH_REGS-1:0] clr;
    clr = '0;
    for (int p = 0; p < rename_pkg::NUM_SLOTS; p++) begin
      if (writes(c[p]) && m_busy[c[p].dst] && m_tag[c[p].dst] == c[p].tag) begin
        clr[c[p].dst] = 1'b1;
      end
    end
    return clr;
  endfunction

  function automatic disp_t predict(input bundle_t b, input commit_t c);
    disp_t                            d;
    logic [rename_pkg::ARCH_REGS-1:0] clr;
    rename_pkg::arch_reg_t            r;
    rename_pkg::rob_tag_t             t;
    clr = clear_mask(c);
    t = m_ptr;
    for (int s = 0; s < rename_pkg::NUM_SLOTS; s++) begin
      d[s].valid = b[s].valid;
      d[s].tag   = t;
      d[s].dst   = b[s].dst;
      if (b[s].valid) t = t + 1'b1;
      for (int i = 0; i < rename_pkg::NUM_SRC; i++) begin
        r = b[s].src[i];
        if (m_busy[r] && !clr[r]) begin
          d[s].src[i] = {1'b0, m_tag[r], 32'h0};
        end else begin
          d[s].src[i] = {1'b1, 4'h0, (r == '0) ? 32'h0 : m_regs[r]};
          for (int p = 0; p < rename_pkg::NUM_SLOTS; p++) begin
            if (writes(c[p]) && c[p].dst == r) d[s].src[i].data = c[p].data;
          end
        end
        if (s == 1 && b[0].valid && b[0].dst != '0 && r == b[0].dst) begin
          d[s].src[i] = {1'b0, d[0].tag, 32'h0};
        end
      end
    end
    return d;
  endfunction

  // predicts the upcoming edge, then advances the model past it
  task automatic update_model();
    logic                             exp_ready;
    logic [rename_pkg::ARCH_REGS-1:0] clr;
    exp_ready = (!m_valid || out_ready_i) && !flush_i &&
                m_cnt <= rename_pkg::ROB_DEPTH - rename_pkg::NUM_SLOTS;
    checks++;
    if (in_ready_o !== exp_ready) begin
      errors++;
      $display("[FAIL] %0t in_ready_o got %b expected %b", $time, in_ready_o, exp_ready);
    end
    last_acc = in_valid_i && exp_ready;
    if (last_acc) begin
      accepts++;
      exp_q.push_back(predict(bundle_i, commit_i));
    end
    clr = clear_mask(commit_i);
    for (int p = 0; p < rename_pkg::NUM_SLOTS; p++) begin
      if (writes(commit_i[p])) m_regs[commit_i[p].dst] = commit_i[p].data;
      if (commit_i[p].valid && rob_q.size() > 0) begin
        void'(rob_q.pop_front());
        m_cnt--;
      end
    end
    if (flush_i) begin
      m_busy = '0;
      m_ptr = '0;
      m_cnt = 0;
      m_valid = 1'b0;
      rob_q.delete();
      exp_q.delete();
    end else begin
      m_busy = m_busy & ~clr;
      for (int s = 0; s < rename_pkg::NUM_SLOTS; s++) begin
        if (last_acc && bundle_i[s].valid) begin
          if (bundle_i[s].dst != '0) begin
            m_busy[bundle_i[s].dst] = 1'b1;
            m_tag[bundle_i[s].dst] = m_ptr;
          end
          rob_q.push_back({bundle_i[s].dst, m_ptr});
          m_ptr = m_ptr + 1'b1;
          m_cnt++;
        end
      end
      if (last_acc) m_valid = 1'b1;
      else if (out_ready_i) m_valid = 1'b0;
    end
  endtask

  // one clock: drive on the falling edge, commits retire the oldest in-flight tags
  task automatic step(input logic vld, input bundle_t b, input int ncommit, input logic ordy,
                      input logic fl);
    @(negedge clk);
    in_valid_i = vld;
    bundle_i = b;
    out_ready_i = ordy;
    flush_i = fl;
    commit_i = '0;
    for (int p = 0; p < rename_pkg::NUM_SLOTS; p++) begin
      if (p < ncommit && p < rob_q.size()) begin
        commit_i[p] = {1'b1, 1'b1, rob_q[p][8:4], rob_q[p][3:0], $urandom};
      end
    end
    #2;
    update_model();
  endtask

  function automatic bundle_t pair(input logic v0, input int a0, input int b0, input int d0,
                                   input logic v1, input int a1, input int b1, input int d1);
    bundle_t b;
    b[0] = {v0, rename_pkg::arch_reg_t'(b0), rename_pkg::arch_reg_t'(a0),
            rename_pkg::arch_reg_t'(d0)};
    b[1] = {v1, rename_pkg::arch_reg_t'(b1), rename_pkg::arch_reg_t'(a1),
            rename_pkg::arch_reg_t'(d1)};
    return b;
  endfunction

  function automatic bundle_t rand_bundle();
    return pair($urandom % 4 != 0, $urandom % 8, $urandom % 8, $urandom % 8,
                $urandom % 4 != 0, $urandom % 8, $urandom % 8, $urandom % 8);
  endfunction

  task automatic drain();
    n = 0;
    while ((rob_q.size() > 0 || m_valid) && n < 50) begin
      step(1'b0, '0, 2, 1'b1, 1'b0);
      n++;
    end
    if (rob_q.size() > 0 || m_valid) begin
      errors++;
      $display("timeout: in-flight work did not drain within 50 cycles");
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s finished with %0d errors", num, name, errors - err_mark);
    err_mark = errors;
  endtask

  always @(negedge clk) begin
    disp_t exp;
    #1;
    if (rst_n) begin
      checks++;
      if (out_valid_o !== m_valid) begin
        errors++;
        $display("[FAIL] %0t out_valid_o got %b expected %b", $time, out_valid_o, m_valid);
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("dispatch handshake at %0t with no bundle predicted", $time);
        end else begin
          exp = exp_q.pop_front();
          checks++;
          if (dispatch_o !== exp) begin
            errors++;
            $display("[FAIL] %0t dispatch_o got %h expected %h", $time, dispatch_o, exp);
          end
        end
      end
    end
  end

  initial begin
    void'($urandom(32'hff7d1b48));
    {clk, rst_n, in_valid_i, flush_i, out_ready_i} = '0;
    bundle_i = '0;
    commit_i = '0;
    {m_busy, m_ptr, m_cnt, m_valid, last_acc} = '0;
    {checks, errors, err_mark, accepts} = '0;
    for (int r = 0; r < rename_pkg::ARCH_REGS; r++) m_regs[r] = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    step(1'b1, pair(1, 1, 2, 3, 1, 4, 5, 6), 0, 1'b1, 1'b0);
    step(1'b0, '0, 0, 1'b1, 1'b0);
    end_test(1, "reset state");

    // r3 commits while a new bundle reads it, then r6 and r0
    step(1'b1, pair(1, 3, 0, 0, 0, 0, 0, 0), 1, 1'b1, 1'b0);
    step(1'b1, pair(1, 6, 3, 0, 1, 0, 6, 0), 2, 1'b1, 1'b0);
    step(1'b1, pair(1, 6, 3, 0, 0, 0, 0, 0), 0, 1'b1, 1'b0);
    drain();
    end_test(2, "commit readback");

    step(1'b1, pair(1, 1, 2, 7, 1, 7, 3, 8), 0, 1'b1, 1'b0);
    step(1'b1, pair(1, 7, 8, 7, 1, 8, 7, 9), 0, 1'b1, 1'b0);
    // older r7 tag retires, newer mapping stays busy
    step(1'b1, pair(1, 7, 9, 0, 0, 0, 0, 0), 1, 1'b1, 1'b0);
    drain();
    end_test(3, "renaming");

    accepts = 0;
    n = 0;
    last_acc = 1'b1;
    while (last_acc && n < 20) begin
      step(1'b1, pair(1, 1, 2, 3, 1, 3, 4, 5), 0, 1'b1, 1'b0);
      n++;
    end
    checks++;
    if (accepts != 8) begin
      errors++;
      $display("[FAIL] %0t accepted bundles got %0d expected 8", $time, accepts);
    end
    n = 0;
    last_acc = 1'b0;
    while (!last_acc && n < 20) begin
      step(1'b1, pair(1, 5, 3, 1, 1, 1, 2, 2), 2, 1'b1, 1'b0);
      n++;
    end
    if (!last_acc) begin
      errors++;
      $display("timeout: commits did not reopen the bundle input");
    end
    drain();
    end_test(4, "ROB back-pressure");

    step(1'b1, pair(1, 1, 2, 3, 1, 3, 4, 5), 0, 1'b0, 1'b0);
    repeat (4) step(1'b1, pair(1, 5, 3, 6, 1, 6, 1, 7), 0, 1'b0, 1'b0);
    step(1'b0, '0, 0, 1'b1, 1'b0);
    repeat (200) step($urandom % 4 != 0, rand_bundle(), $urandom % 3, $urandom % 4 != 0, 1'b0);
    drain();
    end_test(5, "dispatch back-pressure");

    step(1'b1, pair(1, 1, 2, 1, 1, 3, 4, 2), 0, 1'b0, 1'b0);
    step(1'b1, pair(1, 1, 2, 3, 1, 3, 4, 4), 0, 1'b0, 1'b1);
    step(1'b1, pair(1, 1, 2, 5, 1, 3, 4, 6), 0, 1'b1, 1'b0);
    drain();
    end_test(6, "flush");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/arch_regfile.sv
`timescale 1ns/100ps

module arch_regfile (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  rename_pkg::arch_reg_t
         [rename_pkg::NUM_SLOTS-1:0][rename_pkg::NUM_SRC-1:0] raddr_i,
  output rename_pkg::word_t
         [rename_pkg::NUM_SLOTS-1:0][rename_pkg::NUM_SRC-1:0] rdata_o,
  input  rename_pkg::commit_port_t [rename_pkg::NUM_SLOTS-1:0] commit_i
);

  // register 0 has no storage
  rename_pkg::word_t              regs_q [rename_pkg::ARCH_REGS-1:1];
  logic [rename_pkg::NUM_SLOTS-1:0] wr_en;

  always_comb begin
    for (int p = 0; p < rename_pkg::NUM_SLOTS; p++) begin
      wr_en[p] = commit_i[p].valid && commit_i[p].we && commit_i[p].dst != '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 1; r < rename_pkg::ARCH_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      // port 1 last so it wins on a collision
      for (int p = 0; p < rename_pkg::NUM_SLOTS; p++) begin
        if (wr_en[p]) begin
          regs_q[commit_i[p].dst] <= commit_i[p].data;
        end
      end
    end
  end

  // same-cycle writes forwarded, same priority as the write
  always_comb begin
    for (int s = 0; s < rename_pkg::NUM_SLOTS; s++) begin
      for (int i = 0; i < rename_pkg::NUM_SRC; i++) begin
        if (raddr_i[s][i] == '0) begin
          rdata_o[s][i] = '0;
        end else begin
          rdata_o[s][i] = regs_q[raddr_i[s][i]];
          for (int p = 0; p < rename_pkg::NUM_SLOTS; p++) begin
            if (wr_en[p] && commit_i[p].dst == raddr_i[s][i]) begin
              rdata_o[s][i] = commit_i[p].data;
            end
          end
        end
      end
    end
  end

endmodule

// File: verilog/operand_merge.sv
`timescale 1ns/100ps

module operand_merge (
  input  rename_pkg::rename_slot_t [rename_pkg::NUM_SLOTS-1:0] slots_i,
  input  rename_pkg::map_entry_t
         [rename_pkg::NUM_SLOTS-1:0][rename_pkg::NUM_SRC-1:0] entry_i,
  input  rename_pkg::word_t
         [rename_pkg::NUM_SLOTS-1:0][rename_pkg::NUM_SRC-1:0] rdata_i,
  input  rename_pkg::rob_tag_t [rename_pkg::NUM_SLOTS-1:0]     tag_i,
  output rename_pkg::dispatch_slot_t [rename_pkg::NUM_SLOTS-1:0] dispatch_o
);

  logic intra_dep;

  always_comb begin
    intra_dep = 1'b0;
    for (int s = 0; s < rename_pkg::NUM_SLOTS; s++) begin
      dispatch_o[s].valid = slots_i[s].valid;
      dispatch_o[s].tag   = tag_i[s];
      dispatch_o[s].dst   = slots_i[s].dst;
      for (int i = 0; i < rename_pkg::NUM_SRC; i++) begin
        if (entry_i[s][i].busy) begin
          // wait on the in-flight producer
          dispatch_o[s].src[i].ready = 1'b0;
          dispatch_o[s].src[i].tag   = entry_i[s][i].tag;
          dispatch_o[s].src[i].data  = '0;
        end else begin
          dispatch_o[s].src[i].ready = 1'b1;
          dispatch_o[s].src[i].tag   = '0;
          dispatch_o[s].src[i].data  = rdata_i[s][i];
        end

        // slot 1 reading what slot 0 writes in the same bundle
        intra_dep = s == 1 && slots_i[0].valid && slots_i[0].dst != '0 &&
                    slots_i[s].src[i] == slots_i[0].dst;
        if (intra_dep) begin
          dispatch_o[s].src[i].ready = 1'b0;
          dispatch_o[s].src[i].tag   = tag_i[0];
          dispatch_o[s].src[i].data  = '0;
        end
      end
    end
  end

endmodule

// File: verilog/rename_map.sv
`timescale 1ns/100ps

module rename_map (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  rename_pkg::arch_reg_t
         [rename_pkg::NUM_SLOTS-1:0][rename_pkg::NUM_SRC-1:0] rd_arch_i,
  output rename_pkg::map_entry_t
         [rename_pkg::NUM_SLOTS-1:0][rename_pkg::NUM_SRC-1:0] rd_entry_o,
  input  rename_pkg::rename_slot_t [rename_pkg::NUM_SLOTS-1:0] slots_i,
  input  logic                                   alloc_i,
  output rename_pkg::rob_tag_t [rename_pkg::NUM_SLOTS-1:0]     alloc_tag_o,
  input  rename_pkg::commit_port_t [rename_pkg::NUM_SLOTS-1:0] commit_i,
  input  logic                                   flush_i,
  output logic                                   room_o
);

  logic [rename_pkg::ARCH_REGS-1:0] busy_q;
  rename_pkg::rob_tag_t             tag_q [rename_pkg::ARCH_REGS];
  rename_pkg::rob_tag_t             alloc_ptr_q;
  rename_pkg::rob_cnt_t             inflight_q;

  logic [rename_pkg::ARCH_REGS-1:0] clr;
  rename_pkg::rob_tag_t             next_tag;
  rename_pkg::rob_cnt_t             alloc_n;
  rename_pkg::rob_cnt_t             retire_n;

  // tags in slot order, skipping invalid slots
  always_comb begin
    next_tag = alloc_ptr_q;
    for (int s = 0; s < rename_pkg::NUM_SLOTS; s++) begin
      alloc_tag_o[s] = next_tag;
      if (slots_i[s].valid) begin
        next_tag = next_tag + 1'b1;
      end
    end
  end

  always_comb begin
    alloc_n  = '0;
    retire_n = '0;
    for (int s = 0; s < rename_pkg::NUM_SLOTS; s++) begin
      if (alloc_i && slots_i[s].valid) begin
        alloc_n = alloc_n + 1'b1;
      end
      if (commit_i[s].valid) begin
        retire_n = retire_n + 1'b1;
      end
    end
  end

  // commit only clears a mapping that still points at its own tag
  always_comb begin
    clr = '0;
    for (int p = 0; p < rename_pkg::NUM_SLOTS; p++) begin
      if (commit_i[p].valid && commit_i[p].we && commit_i[p].dst != '0 &&
          busy_q[commit_i[p].dst] && tag_q[commit_i[p].dst] == commit_i[p].tag) begin
        clr[commit_i[p].dst] = 1'b1;
      end
    end
  end

  always_comb begin
    for (int s = 0; s < rename_pkg::NUM_SLOTS; s++) begin
      for (int i = 0; i < rename_pkg::NUM_SRC; i++) begin
        rd_entry_o[s][i].busy = busy_q[rd_arch_i[s][i]] & ~clr[rd_arch_i[s][i]];
        rd_entry_o[s][i].tag  = tag_q[rd_arch_i[s][i]];
      end
    end
  end

  assign room_o = inflight_q <=
                  rename_pkg::rob_cnt_t'(rename_pkg::ROB_DEPTH - rename_pkg::NUM_SLOTS);

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      busy_q      <= '0;
      alloc_ptr_q <= '0;
      inflight_q  <= '0;
    end else begin
      busy_q <= busy_q & ~clr;
      // a new rename overrides a same-cycle clear, slot 1 last
      if (alloc_i) begin
        for (int s = 0; s < rename_pkg::NUM_SLOTS; s++) begin
          if (slots_i[s].valid && slots_i[s].dst != '0) begin
            busy_q[slots_i[s].dst] <= 1'b1;
          end
        end
        alloc_ptr_q <= next_tag;
      end
      inflight_q <= inflight_q + alloc_n - retire_n;
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_i) begin
      for (int s = 0; s < rename_pkg::NUM_SLOTS; s++) begin
        if (slots_i[s].valid && slots_i[s].dst != '0) begin
          tag_q[slots_i[s].dst] <= alloc_tag_o[s];
        end
      end
    end
  end

endmodule

// File: verilog/rename_pkg.sv
package rename_pkg;

  localparam int NUM_SLOTS = 2;
  localparam int NUM_SRC   = 2;
  localparam int ARCH_REGS = 32;
  localparam int ROB_DEPTH = 16;
  // in-flight count spans 0 to ROB_DEPTH inclusive
  localparam int ROB_CNT_W = $clog2(ROB_DEPTH + 1);

  typedef logic [31:0]                  word_t;
  typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;
  typedef logic [ROB_CNT_W-1:0]         rob_cnt_t;

  // decoded instruction entering rename
  typedef struct packed {
    logic                      valid;
    arch_reg_t [NUM_SRC-1:0]   src;
    arch_reg_t                 dst;
  } rename_slot_t;

  typedef struct packed {
    logic     busy;
    rob_tag_t tag;
  } map_entry_t;

  // retiring instruction from the ROB head
  typedef struct packed {
    logic      valid;
    logic      we;
    arch_reg_t dst;
    rob_tag_t  tag;
    word_t     data;
  } commit_port_t;

  typedef struct packed {
    logic     ready;
    rob_tag_t tag;
    word_t    data;
  } operand_t;

  typedef struct packed {
    logic                   valid;
    rob_tag_t               tag;
    arch_reg_t              dst;
    operand_t [NUM_SRC-1:0] src;
  } dispatch_slot_t;

endpackage

// File: verilog/rename_stage.sv
`timescale 1ns/100ps

module rename_stage (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 in_valid_i,
  output logic                                                 in_ready_o,
  input  rename_pkg::rename_slot_t [rename_pkg::NUM_SLOTS-1:0]   bundle_i,
  input  rename_pkg::commit_port_t [rename_pkg::NUM_SLOTS-1:0]   commit_i,
  input  logic                                                 flush_i,
  output logic                                                 out_valid_o,
  input  logic                                                 out_ready_i,
  output rename_pkg::dispatch_slot_t [rename_pkg::NUM_SLOTS-1:0] dispatch_o
);

  rename_pkg::arch_reg_t  [rename_pkg::NUM_SLOTS-1:0][rename_pkg::NUM_SRC-1:0] rd_arch;
  rename_pkg::map_entry_t [rename_pkg::NUM_SLOTS-1:0][rename_pkg::NUM_SRC-1:0] map_entry;
  rename_pkg::word_t      [rename_pkg::NUM_SLOTS-1:0][rename_pkg::NUM_SRC-1:0] rd_data;
  rename_pkg::rob_tag_t   [rename_pkg::NUM_SLOTS-1:0]     alloc_tag;
  rename_pkg::dispatch_slot_t [rename_pkg::NUM_SLOTS-1:0] merged;
  rename_pkg::dispatch_slot_t [rename_pkg::NUM_SLOTS-1:0] dispatch_q;

  logic room;
  logic accept;
  logic out_valid_q;

  for (genvar s = 0; s < rename_pkg::NUM_SLOTS; s++) begin : g_addr
    for (genvar i = 0; i < rename_pkg::NUM_SRC; i++) begin : g_src
      assign rd_arch[s][i] = bundle_i[s].src[i];
    end
  end

  // dispatch register free or draining this cycle
  assign in_ready_o = (!out_valid_q || out_ready_i) && room && !flush_i;
  assign accept     = in_valid_i && in_ready_o;

  rename_map i_map (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_arch_i  (rd_arch),
    .rd_entry_o (map_entry),
    .slots_i    (bundle_i),
    .alloc_i    (accept),
    .alloc_tag_o(alloc_tag),
    .commit_i   (commit_i),
    .flush_i    (flush_i),
    .room_o     (room)
  );

  arch_regfile i_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (rd_arch),
    .rdata_o (rd_data),
    .commit_i(commit_i)
  );

  operand_merge i_merge (
    .slots_i   (bundle_i),
    .entry_i   (map_entry),
    .rdata_i   (rd_data),
    .tag_i     (alloc_tag),
    .dispatch_o(merged)
  );

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      out_valid_q <= 1'b0;
    end else if (accept) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // operand snapshot at acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      dispatch_q <= merged;
    end
  end

  assign out_valid_o = out_valid_q;
  assign dispatch_o  = dispatch_q;

endmodule
